//--- dv/systolic_array_checker.sv
`timescale 1ns/100ps

module systolic_array_checker (
    input logic clk,
    input logic rst_n,
    input logic i_start,
    input logic i_busy,
    input logic i_done
);

    // done is a single-cycle pulse
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        i_done |=> !i_done)
        else $error("o_done high on two consecutive cycles");

    // done comes with busy already low
    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        i_done |-> !i_busy)
        else $error("o_busy still high while o_done is set");

    // an accepted start makes the sequencer busy
    a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (i_start && !i_busy) |=> i_busy)
        else $error("start while idle did not raise o_busy");

endmodule

bind systolic_array_top systolic_array_checker systolic_array_checker_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_start (i_start),
    .i_busy  (o_busy),
    .i_done  (o_done)
);

//--- dv/systolic_array_tb.sv
`timescale 1ns/100ps

module systolic_array_tb
    import sa_pkg::*;
();

    localparam int NUM_ROW        = 4;
    localparam int NUM_COL        = 4;
    localparam int ROW_W          = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1;
    localparam int DEPTH          = 2 ** ADDR_WIDTH;
    localparam int TIMEOUT_CYCLES = 500;           // longest run is well below this
    localparam int QUIET_CYCLES   = 40;            // window that must stay free of o_done
    localparam int NUM_TESTS      = 6;

    typedef enum logic [1:0] {
        T_RESET,
        T_RUN,
        T_BUSY
    } test_kind_t;

    // ------------------------------
    // test table
    // ------------------------------
    string      tbl_name  [NUM_TESTS] = '{"after_reset", "single_addr", "full_depth",
                                          "offset_range", "back_to_back", "start_while_busy"};
    bank_addr_t tbl_start [NUM_TESTS] = '{6'd0, 6'd5, 6'd0, 6'd17, 6'd9, 6'd8};
    bank_addr_t tbl_end   [NUM_TESTS] = '{6'd0, 6'd5, 6'd63, 6'd42, 6'd30, 6'd30};
    logic       tbl_fill  [NUM_TESTS] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    test_kind_t tbl_kind  [NUM_TESTS] = '{T_RESET, T_RUN, T_RUN, T_RUN, T_RUN, T_BUSY};

    // ignored request issued while the busy test runs
    localparam bank_addr_t BUSY_START2 = 6'd0;
    localparam bank_addr_t BUSY_END2   = 6'd63;

    logic                   clk;
    logic                   rst_n;
    logic                   i_w_wr_en;
    bank_addr_t             i_w_wr_addr;
    operand_t [NUM_COL-1:0] i_w_wr_data;
    logic                   i_a_wr_en;
    bank_addr_t             i_a_wr_addr;
    operand_t [NUM_ROW-1:0] i_a_wr_data;
    logic                   i_start;
    bank_addr_t             i_rd_start_addr;
    bank_addr_t             i_rd_end_addr;
    logic                   o_busy;
    logic                   o_done;
    logic                   i_res_rd_en;
    logic [ROW_W-1:0]       i_res_rd_addr;
    acc_t [NUM_COL-1:0]     o_res_rd_data;

    operand_t w_model [DEPTH][NUM_COL];            // copy of the weight bank
    operand_t a_model [DEPTH][NUM_ROW];            // copy of the activation bank

    integer seed = 32'h1a4ac247;
    int     cycle_cnt;
    int     run_start_cycle;
    int     err_count;
    int     check_count;
    int     tests_failed;
    logic   timed_out;                             // stops the remaining tests

    systolic_array_top #(
        .NUM_ROW         (NUM_ROW),
        .NUM_COL         (NUM_COL)
    ) systolic_array_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_w_wr_en       (i_w_wr_en),
        .i_w_wr_addr     (i_w_wr_addr),
        .i_w_wr_data     (i_w_wr_data),
        .i_a_wr_en       (i_a_wr_en),
        .i_a_wr_addr     (i_a_wr_addr),
        .i_a_wr_data     (i_a_wr_data),
        .i_start         (i_start),
        .i_rd_start_addr (i_rd_start_addr),
        .i_rd_end_addr   (i_rd_end_addr),
        .o_busy          (o_busy),
        .o_done          (o_done),
        .i_res_rd_en     (i_res_rd_en),
        .i_res_rd_addr   (i_res_rd_addr),
        .o_res_rd_data   (o_res_rd_data)
    );

    always #50 clk = ~clk;                         // 100 ns period

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            err_count++;
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, actual, expected);
        end
    endtask

    task automatic fill_banks();
        operand_t word;
        for (int addr = 0; addr < DEPTH; addr++)
        begin
            @(negedge clk);
            i_w_wr_en   = 1'b1;
            i_a_wr_en   = 1'b1;
            i_w_wr_addr = bank_addr_t'(addr);
            i_a_wr_addr = bank_addr_t'(addr);
            for (int c = 0; c < NUM_COL; c++)
            begin
                word             = operand_t'($random(seed));
                i_w_wr_data[c]   = word;
                w_model[addr][c] = word;
            end
            for (int r = 0; r < NUM_ROW; r++)
            begin
                word             = operand_t'($random(seed));
                i_a_wr_data[r]   = word;
                a_model[addr][r] = word;
            end
        end
        @(negedge clk);
        i_w_wr_en = 1'b0;
        i_a_wr_en = 1'b0;
    endtask

    // sum over the range of activation r times weight c, mod 2^32
    function automatic acc_t expected_acc(input int row, input int col,
                                          input bank_addr_t first, input bank_addr_t last);
        acc_t sum;
        sum = '0;
        for (int k = int'(first); k <= int'(last); k++)
            sum = sum + acc_t'(a_model[k][row]) * acc_t'(w_model[k][col]);
        return sum;
    endfunction

    task automatic start_run(input bank_addr_t first, input bank_addr_t last);
        @(negedge clk);
        i_start         = 1'b1;
        i_rd_start_addr = first;
        i_rd_end_addr   = last;
        run_start_cycle = cycle_cnt;
        @(negedge clk);
        i_start = 1'b0;
    endtask

    task automatic wait_done(output int latency);
        int   waited;
        logic seen;
        waited  = 0;
        seen    = 1'b0;
        latency = 0;
        while (!seen && waited < TIMEOUT_CYCLES)
        begin
            @(negedge clk);
            waited++;
            if (o_done)
                seen = 1'b1;
        end
        if (!seen)
        begin
            err_count++;
            timed_out = 1'b1;
            $display("timeout: o_done never came after the run was started");
        end
        else
        begin
            latency = cycle_cnt - run_start_cycle;
        end
    endtask

    task automatic count_done_pulses(input int cycles, output int pulses);
        pulses = 0;
        for (int n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            if (o_done)
                pulses++;
        end
    endtask

    task automatic check_results(input bank_addr_t first, input bank_addr_t last,
                                 input logic expect_zero);
        acc_t  exp_val;
        string sig;
        for (int r = 0; r < NUM_ROW; r++)
        begin
            @(negedge clk);
            i_res_rd_en   = 1'b1;
            i_res_rd_addr = ROW_W'(r);
            @(negedge clk);
            i_res_rd_en   = 1'b0;                  // data holds until the next read
            for (int c = 0; c < NUM_COL; c++)
            begin
                exp_val = expect_zero ? acc_t'(0) : expected_acc(r, c, first, last);
                sig     = $sformatf("o_res_rd_data[row %0d][col %0d]", r, c);
                check_value(sig, o_res_rd_data[c], exp_val);
            end
        end
    endtask

    task automatic run_test(input int idx);
        int latency;
        int extra_done;
        int errs_before;
        int depth;
        errs_before = err_count;
        depth       = int'(tbl_end[idx]) - int'(tbl_start[idx]) + 1;
        if (tbl_fill[idx])
            fill_banks();
        case (tbl_kind[idx])
            T_RESET:
            begin
                check_value("o_busy", 32'(o_busy), 32'h0);
                check_value("o_done", 32'(o_done), 32'h0);
                check_results(tbl_start[idx], tbl_end[idx], 1'b1);
            end
            T_RUN:
            begin
                start_run(tbl_start[idx], tbl_end[idx]);
                wait_done(latency);
                if (!timed_out)
                begin
                    check_value("done latency", latency, depth + NUM_ROW + NUM_COL + 3);
                    check_results(tbl_start[idx], tbl_end[idx], 1'b0);
                end
            end
            default:
            begin
                start_run(tbl_start[idx], tbl_end[idx]);
                repeat (3) @(negedge clk);
                check_value("o_busy", 32'(o_busy), 32'h1);
                i_start         = 1'b1;            // must be ignored
                i_rd_start_addr = BUSY_START2;
                i_rd_end_addr   = BUSY_END2;
                @(negedge clk);
                i_start = 1'b0;
                wait_done(latency);
                if (!timed_out)
                begin
                    check_value("done latency", latency, depth + NUM_ROW + NUM_COL + 3);
                    count_done_pulses(QUIET_CYCLES, extra_done);
                    check_value("extra o_done pulses", extra_done, 32'h0);
                    check_value("o_busy", 32'(o_busy), 32'h0);
                    check_results(tbl_start[idx], tbl_end[idx], 1'b0);
                end
            end
        endcase
        if (err_count == errs_before)
        begin
            $display("test %0d %-16s : pass", idx, tbl_name[idx]);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %-16s : fail, %0d errors", idx, tbl_name[idx],
                     err_count - errs_before);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial
    begin
        clk             = 1'b0;
        rst_n           = 1'b1;
        i_w_wr_en       = 1'b0;
        i_w_wr_addr     = '0;
        i_w_wr_data     = '0;
        i_a_wr_en       = 1'b0;
        i_a_wr_addr     = '0;
        i_a_wr_data     = '0;
        i_start         = 1'b0;
        i_rd_start_addr = '0;
        i_rd_end_addr   = '0;
        i_res_rd_en     = 1'b0;
        i_res_rd_addr   = '0;
        cycle_cnt       = 0;
        err_count       = 0;
        check_count     = 0;
        tests_failed    = 0;
        timed_out       = 1'b0;

        #10 rst_n = 1'b0;
        repeat (4) @(posedge clk);                 // four edges in reset
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int t = 0; t < NUM_TESTS && !timed_out; t++)
            run_test(t);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 NUM_TESTS, tests_failed, check_count, err_count);
        if (err_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the systolic array testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=systolic_array_sim

verilator --binary --timing --assert \
    -f systolic_array.f \
    --top-module systolic_array_tb \
    -Mdir obj_dir -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed"
    exit 1
fi

./obj_dir/"$SIM_BIN" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

//--- source/sa_operand_bank.sv
`timescale 1ns/100ps

module sa_operand_bank
    import sa_pkg::*;
#(
    parameter int NUM_LANES = 4
)(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_wr_en,
    input  bank_addr_t               i_wr_addr,
    input  operand_t [NUM_LANES-1:0] i_wr_data,
    input  logic                     i_rd_en,
    input  bank_addr_t               i_rd_addr,
    output operand_t [NUM_LANES-1:0] o_rd_data,
    output logic                     o_rd_valid
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // one word holds every lane at that address
    operand_t [NUM_LANES-1:0] mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;          // all lanes in one cycle
    end

    // registered read, one cycle of latency
    always_ff @(posedge clk)
    begin
        if (i_rd_en)
            o_rd_data <= mem[i_rd_addr];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_rd_valid <= 1'b0;
        else
            o_rd_valid <= i_rd_en;                // tracks the read data
    end

endmodule

//--- source/sa_pe_array.sv
`timescale 1ns/100ps

module sa_pe_array
    import sa_pkg::*;
#(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
)(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_clear,
    input  operand_t [NUM_ROW-1:0]         i_left_data,
    input  logic     [NUM_ROW-1:0]         i_left_valid,
    input  operand_t [NUM_COL-1:0]         i_top_data,
    input  logic     [NUM_COL-1:0]         i_top_valid,
    output acc_t     [NUM_ROW*NUM_COL-1:0] o_acc        // row-major, r*NUM_COL+c
);

    // operands as seen at the input of each cell
    operand_t a_in  [NUM_ROW][NUM_COL];           // from the left
    logic     a_vld [NUM_ROW][NUM_COL];
    operand_t b_in  [NUM_ROW][NUM_COL];           // from the top
    logic     b_vld [NUM_ROW][NUM_COL];

    for (genvar gr = 0; gr < NUM_ROW; gr++)
    begin : g_row
        for (genvar gc = 0; gc < NUM_COL; gc++)
        begin : g_col
            acc_t acc_q;

            // ------------------------------
            // horizontal operand path
            // ------------------------------
            if (gc == 0)
            begin : g_a_edge
                assign a_in[gr][gc]  = i_left_data[gr];
                assign a_vld[gr][gc] = i_left_valid[gr];
            end
            else
            begin : g_a_hop
                operand_t a_q;
                logic     a_vld_q;

                always_ff @(posedge clk)
                    a_q <= a_in[gr][gc-1];        // one cell per cycle

                always_ff @(posedge clk or negedge rst_n)
                begin
                    if (!rst_n)
                        a_vld_q <= 1'b0;
                    else
                        a_vld_q <= a_vld[gr][gc-1];
                end

                assign a_in[gr][gc]  = a_q;
                assign a_vld[gr][gc] = a_vld_q;
            end

            // ------------------------------
            // vertical operand path
            // ------------------------------
            if (gr == 0)
            begin : g_b_edge
                assign b_in[gr][gc]  = i_top_data[gc];
                assign b_vld[gr][gc] = i_top_valid[gc];
            end
            else
            begin : g_b_hop
                operand_t b_q;
                logic     b_vld_q;

                always_ff @(posedge clk)
                    b_q <= b_in[gr-1][gc];

                always_ff @(posedge clk or negedge rst_n)
                begin
                    if (!rst_n)
                        b_vld_q <= 1'b0;
                    else
                        b_vld_q <= b_vld[gr-1][gc];
                end

                assign b_in[gr][gc]  = b_q;
                assign b_vld[gr][gc] = b_vld_q;
            end

            // multiply-accumulate, clear wins over a product
            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                    acc_q <= '0;
                else if (i_clear)
                    acc_q <= '0;
                else if (a_vld[gr][gc] && b_vld[gr][gc])
                    acc_q <= acc_q + acc_t'(a_in[gr][gc]) * acc_t'(b_in[gr][gc]);
            end

            assign o_acc[gr*NUM_COL + gc] = acc_q;
        end
    end

endmodule

//--- source/sa_pkg.sv
package sa_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int DATA_WIDTH = 8;                // one operand word
    localparam int ACC_WIDTH  = 32;               // accumulator, wraps mod 2^32
    localparam int ADDR_WIDTH = 6;                // 64 words per lane

    // ------------------------------
    // types
    // ------------------------------
    typedef logic [DATA_WIDTH-1:0] operand_t;     // unsigned operand
    typedef logic [ACC_WIDTH-1:0]  acc_t;
    typedef logic [ADDR_WIDTH-1:0] bank_addr_t;

    // run control states
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,
        SEQ_FEED    = 2'd1,                       // issuing bank addresses
        SEQ_FLUSH   = 2'd2,                       // last operands still in flight
        SEQ_CAPTURE = 2'd3                        // single cycle, results stored
    } seq_state_t;

endpackage

//--- source/sa_result_store.sv
`timescale 1ns/100ps

module sa_result_store
    import sa_pkg::*;
#(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4,
    localparam int ROW_W  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1
)(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       i_capture,
    input  acc_t [NUM_ROW*NUM_COL-1:0] i_acc,
    input  logic                       i_res_rd_en,
    input  logic [ROW_W-1:0]           i_res_rd_addr,   // row index
    output acc_t [NUM_COL-1:0]         o_res_rd_data
);

    acc_t [NUM_ROW*NUM_COL-1:0] res_q;            // whole grid, row-major

    // snapshot of every accumulator at once
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            res_q <= '0;
        else if (i_capture)
            res_q <= i_acc;
    end

    // row read, holds between reads
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_res_rd_data <= '0;
        else if (i_res_rd_en)
            o_res_rd_data <= res_q[i_res_rd_addr*NUM_COL +: NUM_COL];
    end

endmodule

//--- source/sa_sequencer.sv
`timescale 1ns/100ps

module sa_sequencer
    import sa_pkg::*;
#(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4
)(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_start,
    input  bank_addr_t i_rd_start_addr,
    input  bank_addr_t i_rd_end_addr,
    output logic       o_rd_en,
    output bank_addr_t o_rd_addr,
    output logic       o_clear,
    output logic       o_capture,
    output logic       o_busy,
    output logic       o_done
);

    // bank latency + skew + grid propagation, with one cycle of margin
    localparam int FLUSH_LEN = NUM_ROW + NUM_COL + 1;
    localparam int FLUSH_W   = $clog2(FLUSH_LEN);

    seq_state_t         state_q;
    bank_addr_t         addr_q;                   // current read address
    bank_addr_t         end_q;                    // last address of the run
    logic [FLUSH_W-1:0] flush_cnt_q;
    logic               clear_q;
    logic               done_q;

    // ------------------------------
    // run control
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q     <= SEQ_IDLE;
            addr_q      <= '0;
            end_q       <= '0;
            flush_cnt_q <= '0;
            clear_q     <= 1'b0;
            done_q      <= 1'b0;
        end
        else
        begin
            clear_q <= 1'b0;                      // both are single-cycle pulses
            done_q  <= 1'b0;
            case (state_q)
                SEQ_IDLE:
                begin
                    if (i_start)                  // start is only seen here
                    begin
                        state_q <= SEQ_FEED;
                        addr_q  <= i_rd_start_addr;
                        end_q   <= i_rd_end_addr;
                        clear_q <= 1'b1;          // zero accumulators for the new run
                    end
                end
                SEQ_FEED:
                begin
                    if (addr_q == end_q)
                    begin
                        state_q     <= SEQ_FLUSH;
                        flush_cnt_q <= '0;
                    end
                    else
                    begin
                        addr_q <= addr_q + 1'b1;
                    end
                end
                SEQ_FLUSH:
                begin
                    if (flush_cnt_q == FLUSH_W'(FLUSH_LEN - 1))
                        state_q <= SEQ_CAPTURE;
                    else
                        flush_cnt_q <= flush_cnt_q + 1'b1;
                end
                SEQ_CAPTURE:
                begin
                    state_q <= SEQ_IDLE;
                    done_q  <= 1'b1;              // lines up with busy falling
                end
                default:
                begin
                    state_q <= SEQ_IDLE;
                end
            endcase
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------
    assign o_rd_en   = (state_q == SEQ_FEED);
    assign o_rd_addr = addr_q;
    assign o_clear   = clear_q;
    assign o_capture = (state_q == SEQ_CAPTURE);
    assign o_busy    = (state_q != SEQ_IDLE);
    assign o_done    = done_q;

endmodule

//--- source/sa_skew.sv
`timescale 1ns/100ps

module sa_skew
    import sa_pkg::*;
#(
    parameter int NUM_LANES = 4
)(
    input  logic                     clk,
    input  logic                     rst_n,
    input  operand_t [NUM_LANES-1:0] i_data,
    input  logic                     i_valid,
    output operand_t [NUM_LANES-1:0] o_data,
    output logic     [NUM_LANES-1:0] o_valid
);

    // lane i goes through i register stages
    for (genvar gi = 0; gi < NUM_LANES; gi++)
    begin : g_lane
        if (gi == 0)
        begin : g_pass
            assign o_data[gi]  = i_data[gi];      // lane 0 has no delay
            assign o_valid[gi] = i_valid;
        end
        else
        begin : g_dly
            operand_t data_q  [gi];
            logic     valid_q [gi];

            always_ff @(posedge clk)
            begin
                data_q[0] <= i_data[gi];
                for (int k = 1; k < gi; k++)
                    data_q[k] <= data_q[k-1];
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    for (int k = 0; k < gi; k++)
                        valid_q[k] <= 1'b0;
                end
                else
                begin
                    valid_q[0] <= i_valid;
                    for (int k = 1; k < gi; k++)
                        valid_q[k] <= valid_q[k-1];
                end
            end

            assign o_data[gi]  = data_q[gi-1];    // tail of the chain
            assign o_valid[gi] = valid_q[gi-1];
        end
    end

endmodule

//--- source/systolic_array_top.sv
`timescale 1ns/100ps

module systolic_array_top
    import sa_pkg::*;
#(
    parameter int NUM_ROW = 4,
    parameter int NUM_COL = 4,
    localparam int ROW_W  = (NUM_ROW > 1) ? $clog2(NUM_ROW) : 1
)(
    input  logic                   clk,
    input  logic                   rst_n,
    // weight bank, one lane per column
    input  logic                   i_w_wr_en,
    input  bank_addr_t             i_w_wr_addr,
    input  operand_t [NUM_COL-1:0] i_w_wr_data,
    // activation bank, one lane per row
    input  logic                   i_a_wr_en,
    input  bank_addr_t             i_a_wr_addr,
    input  operand_t [NUM_ROW-1:0] i_a_wr_data,
    // run control
    input  logic                   i_start,
    input  bank_addr_t             i_rd_start_addr,
    input  bank_addr_t             i_rd_end_addr,
    output logic                   o_busy,
    output logic                   o_done,
    // result read
    input  logic                   i_res_rd_en,
    input  logic [ROW_W-1:0]       i_res_rd_addr,
    output acc_t [NUM_COL-1:0]     o_res_rd_data
);

    logic                       seq_rd_en;
    bank_addr_t                 seq_rd_addr;
    logic                       seq_clear;
    logic                       seq_capture;

    operand_t [NUM_COL-1:0]     w_rd_data;        // weight lanes, before skew
    logic                       w_rd_valid;
    operand_t [NUM_ROW-1:0]     a_rd_data;        // activation lanes, before skew
    logic                       a_rd_valid;

    operand_t [NUM_COL-1:0]     w_skew_data;
    logic     [NUM_COL-1:0]     w_skew_valid;
    operand_t [NUM_ROW-1:0]     a_skew_data;
    logic     [NUM_ROW-1:0]     a_skew_valid;

    acc_t [NUM_ROW*NUM_COL-1:0] pe_acc;

    // ------------------------------
    // control
    // ------------------------------
    sa_sequencer #(
        .NUM_ROW         (NUM_ROW),
        .NUM_COL         (NUM_COL)
    ) sa_sequencer_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_start         (i_start),
        .i_rd_start_addr (i_rd_start_addr),
        .i_rd_end_addr   (i_rd_end_addr),
        .o_rd_en         (seq_rd_en),
        .o_rd_addr       (seq_rd_addr),
        .o_clear         (seq_clear),
        .o_capture       (seq_capture),
        .o_busy          (o_busy),
        .o_done          (o_done)
    );

    // ------------------------------
    // operand banks
    // ------------------------------
    sa_operand_bank #(
        .NUM_LANES  (NUM_COL)
    ) sa_weight_bank_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_en    (i_w_wr_en),
        .i_wr_addr  (i_w_wr_addr),
        .i_wr_data  (i_w_wr_data),
        .i_rd_en    (seq_rd_en),
        .i_rd_addr  (seq_rd_addr),
        .o_rd_data  (w_rd_data),
        .o_rd_valid (w_rd_valid)
    );

    sa_operand_bank #(
        .NUM_LANES  (NUM_ROW)
    ) sa_act_bank_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_wr_en    (i_a_wr_en),
        .i_wr_addr  (i_a_wr_addr),
        .i_wr_data  (i_a_wr_data),
        .i_rd_en    (seq_rd_en),
        .i_rd_addr  (seq_rd_addr),
        .o_rd_data  (a_rd_data),
        .o_rd_valid (a_rd_valid)
    );

    // ------------------------------
    // skew, array, results
    // ------------------------------
    sa_skew #(
        .NUM_LANES (NUM_COL)
    ) sa_weight_skew_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_data    (w_rd_data),
        .i_valid   (w_rd_valid),
        .o_data    (w_skew_data),
        .o_valid   (w_skew_valid)
    );

    sa_skew #(
        .NUM_LANES (NUM_ROW)
    ) sa_act_skew_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_data    (a_rd_data),
        .i_valid   (a_rd_valid),
        .o_data    (a_skew_data),
        .o_valid   (a_skew_valid)
    );

    sa_pe_array #(
        .NUM_ROW      (NUM_ROW),
        .NUM_COL      (NUM_COL)
    ) sa_pe_array_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_clear      (seq_clear),
        .i_left_data  (a_skew_data),
        .i_left_valid (a_skew_valid),
        .i_top_data   (w_skew_data),
        .i_top_valid  (w_skew_valid),
        .o_acc        (pe_acc)
    );

    sa_result_store #(
        .NUM_ROW       (NUM_ROW),
        .NUM_COL       (NUM_COL)
    ) sa_result_store_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_capture     (seq_capture),
        .i_acc         (pe_acc),
        .i_res_rd_en   (i_res_rd_en),
        .i_res_rd_addr (i_res_rd_addr),
        .o_res_rd_data (o_res_rd_data)
    );

endmodule

//--- systolic_array.f
source/sa_pkg.sv
source/sa_sequencer.sv
source/sa_operand_bank.sv
source/sa_skew.sv
source/sa_pe_array.sv
source/sa_result_store.sv
source/systolic_array_top.sv
dv/systolic_array_checker.sv
dv/systolic_array_tb.sv
